/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_mem_subsystem
FILELIST  ?= project.f

SIM_BIN = obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove obj_dir"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./$(SIM_BIN)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

/* project.f */
verilog/rv32i_types.sv
verilog/mem_stage.sv
verilog/byte_bank.sv
verilog/writeback.sv
verilog/mem_subsystem.sv
testbench/tb_mem_subsystem.sv

/* testbench/tb_mem_subsystem.sv */
`timescale 1ns/1ps

module tb_mem_subsystem
    import rv32i_types::*;
();

    // roughly 480 cycles of stimulus plus margin
    localparam int MAX_CYCLES = 1000;

    logic          clk = 1'b0;
    logic          reset;
    ex_mem_stage_t mem_in;
    wb_result_t    wb_out;

    // model state
    logic [31:0]   shadow [256];
    wb_result_t    exp_wb;
    logic          chk_on = 1'b0;
    logic [31:0]   lcg_state = 32'h1257;
    int            errors = 0;
    int            sent = 0;
    int            cycles = 0;

    load_funct3_t  load_widths [5] = '{lb, lh, lw, lbu, lhu};
    rv32i_opcode_t other_ops [7] = '{op_lui, op_auipc, op_jal, op_jalr, op_br, op_imm, op_reg};
    logic [31:0]   word_addrs [4] = '{32'h000, 32'h004, 32'h3FC, 32'h120};

    mem_subsystem dut (
        .clk    (clk),
        .reset  (reset),
        .mem_in (mem_in),
        .wb_out (wb_out)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // upper bits since the low LCG bits cycle too fast
    function automatic int rand_below(int n);
        return int'((lcg() >> 16) % n);
    endfunction

    // one EX/MEM record where alu_out follows the address and u_imm the data
    function automatic ex_mem_stage_t make_rec(logic valid, rv32i_opcode_t op,
                                               logic [2:0] width, logic [4:0] rd,
                                               logic [31:0] addr, logic [31:0] data);
        ex_mem_stage_t r;
        r = '0;
        r.valid = valid;
        r.ctrl_wd.opcode = op;
        r.ctrl_wd.mem_ctrlwd.mem_read = (op == op_load);
        r.ctrl_wd.mem_ctrlwd.mem_write = (op == op_store);
        r.ctrl_wd.mem_ctrlwd.load_funct3 = load_funct3_t'(width);
        r.ctrl_wd.mem_ctrlwd.store_funct3 = store_funct3_t'(width);
        r.rd = rd;
        r.alu_out = addr;
        r.mar = addr;
        r.mem_data_out = data;
        r.u_imm = data;
        return r;
    endfunction

    // expected register write from a record and the word it reads
    function automatic wb_result_t expected_wb(ex_mem_stage_t r, logic [31:0] word);
        wb_result_t e;
        logic [31:0] shifted;
        e.rd = r.rd;
        e.reg_write = r.valid && (r.ctrl_wd.opcode != op_store)
                      && (r.ctrl_wd.opcode != op_br) && (r.rd != 5'd0);
        // addressed byte or halfword moved down to bit 0
        shifted = word >> (8 * r.mar[1:0]);
        if (r.ctrl_wd.opcode == op_load) begin
            case (r.ctrl_wd.mem_ctrlwd.load_funct3)
                lb:      e.value = 32'(signed'(shifted[7:0]));
                lbu:     e.value = 32'(shifted[7:0]);
                lh:      e.value = 32'(signed'(shifted[15:0]));
                lhu:     e.value = 32'(shifted[15:0]);
                default: e.value = word;
            endcase
        end else if (r.ctrl_wd.opcode == op_lui) begin
            e.value = r.u_imm;
        end else begin
            e.value = r.alu_out;
        end
        return e;
    endfunction

    // word after a store with only the covered bytes replaced
    function automatic logic [31:0] stored_word(ex_mem_stage_t r, logic [31:0] word);
        int nbytes;
        int off;
        off = int'(r.mar[1:0]);
        case (r.ctrl_wd.mem_ctrlwd.store_funct3)
            sw:      nbytes = 4;
            sh:      nbytes = 2;
            default: nbytes = 1;
        endcase
        for (int b = 0; b < nbytes; b++) begin
            word[8*(off+b) +: 8] = r.mem_data_out[8*b +: 8];
        end
        return word;
    endfunction

    task automatic send(ex_mem_stage_t r);
        @(posedge clk);
        mem_in <= r;
        sent = sent + 1;
    endtask

    // record consumed at this edge has its result due at the next one
    always @(posedge clk) begin
        chk_on <= 1'b1;
        if (reset) begin
            exp_wb <= '0;
        end else begin
            exp_wb <= expected_wb(mem_in, shadow[mem_in.mar[9:2]]);
            if (mem_in.valid && mem_in.ctrl_wd.opcode == op_store) begin
                shadow[mem_in.mar[9:2]] = stored_word(mem_in, shadow[mem_in.mar[9:2]]);
            end
        end
    end

    a_reg_write: assert property (@(posedge clk)
        chk_on |-> (wb_out.reg_write === exp_wb.reg_write))
        else begin
            $display("ERR %0t wb_out.reg_write got %b expected %b", $time,
                     $sampled(wb_out.reg_write), $sampled(exp_wb.reg_write));
            errors = errors + 1;
        end

    // rd and value only matter on a real write
    a_rd: assert property (@(posedge clk)
        (chk_on && exp_wb.reg_write) |-> (wb_out.rd === exp_wb.rd))
        else begin
            $display("ERR %0t wb_out.rd got %0d expected %0d", $time,
                     $sampled(wb_out.rd), $sampled(exp_wb.rd));
            errors = errors + 1;
        end

    a_value: assert property (@(posedge clk)
        (chk_on && exp_wb.reg_write) |-> (wb_out.value === exp_wb.value))
        else begin
            $display("ERR %0t wb_out.value got %h expected %h", $time,
                     $sampled(wb_out.value), $sampled(exp_wb.value));
            errors = errors + 1;
        end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: stimulus still running after %0d cycles, %0d errors",
                     MAX_CYCLES, errors);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        int            sel;
        int            off;
        logic          valid;
        logic [4:0]    rd;
        logic [31:0]   data;
        logic [31:0]   addr;
        logic [2:0]    width;
        rv32i_opcode_t op;
        logic [7:0]    bval;
        logic [15:0]   hval;
        reset <= 1'b1;
        mem_in <= '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // word store then load right behind it
        for (int i = 0; i < 4; i++) begin
            send(make_rec(1'b1, op_store, sw, 5'd0, word_addrs[i], 32'h9E37_79B9 * 32'(i + 1)));
            send(make_rec(1'b1, op_load, lw, 5'(i + 1), word_addrs[i], 32'h0));
        end
        // two stores in flight then both loads
        send(make_rec(1'b1, op_store, sw, 5'd0, 32'h008, 32'h0F0F_8080));
        send(make_rec(1'b1, op_store, sw, 5'd0, 32'h00C, 32'h7F7F_0101));
        send(make_rec(1'b1, op_load, lw, 5'd8, 32'h008, 32'h0));
        send(make_rec(1'b1, op_load, lw, 5'd9, 32'h00C, 32'h0));

        // single bytes with the top bit set on even lanes and clear on odd
        for (int o = 0; o < 4; o++) begin
            bval = o[0] ? 8'h5A : 8'hC3;
            send(make_rec(1'b1, op_store, sw, 5'd0, 32'h040, 32'h80FF_017F));
            // junk above the byte must not land
            send(make_rec(1'b1, op_store, sb, 5'd0, 32'h040 + 32'(o), {24'hFFFFFF, bval}));
            send(make_rec(1'b1, op_load, lb, 5'd10, 32'h040 + 32'(o), 32'h0));
            send(make_rec(1'b1, op_load, lbu, 5'd11, 32'h040 + 32'(o), 32'h0));
            send(make_rec(1'b1, op_load, lw, 5'd12, 32'h040, 32'h0));
        end
        // halfwords at both legal offsets
        for (int o = 0; o < 4; o += 2) begin
            hval = (o == 0) ? 16'h8001 : 16'h7FFE;
            send(make_rec(1'b1, op_store, sw, 5'd0, 32'h040, 32'h80FF_017F));
            send(make_rec(1'b1, op_store, sh, 5'd0, 32'h040 + 32'(o), {16'hDEAD, hval}));
            send(make_rec(1'b1, op_load, lh, 5'd13, 32'h040 + 32'(o), 32'h0));
            send(make_rec(1'b1, op_load, lhu, 5'd14, 32'h040 + 32'(o), 32'h0));
            // untouched half
            send(make_rec(1'b1, op_load, lh, 5'd15, 32'h040 + 32'(2 - o), 32'h0));
            send(make_rec(1'b1, op_load, lw, 5'd16, 32'h040, 32'h0));
        end

        // result mux and suppressed writes
        send(make_rec(1'b1, op_imm, 3'd0, 5'd5, 32'hDEAD_BEEF, 32'h0));
        send(make_rec(1'b1, op_reg, 3'd0, 5'd31, 32'h0000_0001, 32'hFFFF_FFFF));
        send(make_rec(1'b1, op_lui, 3'd0, 5'd7, 32'h1111_1111, 32'hABCD_E000));
        send(make_rec(1'b1, op_auipc, 3'd0, 5'd4, 32'h0000_1004, 32'h0000_1000));
        send(make_rec(1'b1, op_imm, 3'd0, 5'd0, 32'h1234_5678, 32'h0));
        send(make_rec(1'b1, op_br, 3'd0, 5'd3, 32'h0000_0040, 32'h0));
        send(make_rec(1'b1, op_store, sw, 5'd9, 32'h044, 32'h0BAD_CAFE));
        send(make_rec(1'b1, op_load, lw, 5'd0, 32'h040, 32'h0));

        // bubbles with store controls leave memory alone
        send(make_rec(1'b1, op_store, sw, 5'd0, 32'h080, 32'h1357_9BDF));
        send(make_rec(1'b0, op_store, sw, 5'd6, 32'h080, 32'hFFFF_FFFF));
        send(make_rec(1'b0, op_store, sb, 5'd6, 32'h081, 32'hA5A5_A5A5));
        send(make_rec(1'b0, op_load, lw, 5'd6, 32'h080, 32'h0));
        send(make_rec(1'b1, op_load, lw, 5'd17, 32'h080, 32'h0));

        // fill the random window so every load hits a written word
        for (int w = 0; w < 16; w++) begin
            send(make_rec(1'b1, op_store, sw, 5'd0, 32'h200 + 32'(4 * w), lcg()));
        end

        for (int n = 0; n < 400; n++) begin
            sel = rand_below(13);
            valid = (rand_below(8) != 0);
            rd = 5'(rand_below(32));
            data = lcg();
            if (sel < 3) begin
                op = op_load;
                width = load_widths[rand_below(5)];
            end else if (sel < 6) begin
                op = op_store;
                width = 3'(rand_below(3));
            end else begin
                op = other_ops[sel - 6];
                width = 3'(rand_below(8));
            end
            // offset legal for the access size
            case (width[1:0])
                2'b00:   off = rand_below(4);
                2'b01:   off = 2 * rand_below(2);
                default: off = 0;
            endcase
            if (op == op_load || op == op_store) begin
                addr = 32'h200 + 32'(4 * rand_below(16) + off);
            end else begin
                addr = lcg();
            end
            send(make_rec(valid, op, width, rd, addr, data));
        end

        // drain both stages
        send(make_rec(1'b0, op_imm, 3'd0, 5'd0, 32'h0, 32'h0));
        repeat (3) @(posedge clk);
        #1;
        $display("records sent: %0d, errors: %0d", sent, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* verilog/byte_bank.sv */
`timescale 1ns/1ps

module byte_bank
    import rv32i_types::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic [DMEM_ADDR_WIDTH-1:0] index,
    input  logic [7:0]                 wdata,
    input  logic                       write,
    input  logic                       read,
    output logic [7:0]                 rdata
);

    // one byte lane of every word
    logic [7:0] mem [2 ** DMEM_ADDR_WIDTH];

    // write on the closing edge of the cycle
    always_ff @(posedge clk) begin
        if (write) begin
            mem[index] <= wdata;
        end
    end

    // registered read that holds its value between loads
    always_ff @(posedge clk) begin
        if (read) begin
            rdata <= mem[index];
        end
    end

    // an X index would corrupt or read an unknown word
    a_index_known: assert property (
        @(posedge clk) disable iff (reset)
        (write || read) |-> !$isunknown(index)
    ) else $error("byte_bank: unknown index on access");

endmodule

/* verilog/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage
    import rv32i_types::*;
(
    input  ex_mem_stage_t                  mem_in,
    output mem_wb_stage_t                  mem_out,
    output logic [DMEM_ADDR_WIDTH-1:0]     dmem_index,
    output logic [31:0]                    dmem_wdata,
    output logic [3:0]                     mem_byte_enable,
    output logic                           dmem_read
);

    logic          is_store;
    logic [1:0]    offset;
    store_funct3_t st_width;
    load_funct3_t  ld_width;

    assign offset   = mem_in.mar[1:0];
    assign st_width = mem_in.ctrl_wd.mem_ctrlwd.store_funct3;
    assign ld_width = mem_in.ctrl_wd.mem_ctrlwd.load_funct3;
    // bubbles never touch memory
    assign is_store = mem_in.valid && (mem_in.ctrl_wd.opcode == op_store);

    // word index with the byte offset dropped
    assign dmem_index = mem_in.mar[DMEM_ADDR_WIDTH+1:2];

    // read strobe only for a real load
    assign dmem_read = mem_in.valid && mem_in.ctrl_wd.mem_ctrlwd.mem_read;

    // move store source into the addressed lanes
    always_comb begin
        case (st_width)
            sw: dmem_wdata = mem_in.mem_data_out;
            sh: dmem_wdata = offset[1] ? (mem_in.mem_data_out << 16) : mem_in.mem_data_out;
            sb: dmem_wdata = mem_in.mem_data_out << (8 * offset);
            default: dmem_wdata = mem_in.mem_data_out;
        endcase
    end

    // per-lane write mask
    always_comb begin
        mem_byte_enable = 4'b0000;
        if (is_store) begin
            case (st_width)
                sw: mem_byte_enable = 4'b1111;
                // low or high halfword
                sh: mem_byte_enable = offset[1] ? 4'b1100 : 4'b0011;
                sb: mem_byte_enable = 4'b0001 << offset;
                default: mem_byte_enable = 4'b0000;
            endcase
        end
    end

    // record passes through with only the offset bits of the address
    always_comb begin
        mem_out.valid   = mem_in.valid;
        mem_out.ctrl_wd = mem_in.ctrl_wd;
        mem_out.rd      = mem_in.rd;
        mem_out.alu_out = mem_in.alu_out;
        mem_out.u_imm   = mem_in.u_imm;
        mem_out.mar_low = offset;
    end

    // contract checks on each real record
    always_comb begin
        if (mem_in.valid) begin
            // a record is a load or a store but never both
            assert (!(dmem_read && (|mem_byte_enable)))
                else $error("mem_stage: read and write requested together");
            // halfword accesses must sit on an even address
            if ((is_store && st_width == sh) || (dmem_read && (ld_width inside {lh, lhu})))
                assert (offset[0] == 1'b0)
                    else $error("mem_stage: misaligned halfword at %h", mem_in.mar);
            // word accesses must sit on a word boundary
            if ((is_store && st_width == sw) || (dmem_read && ld_width == lw))
                assert (offset == 2'b00)
                    else $error("mem_stage: misaligned word at %h", mem_in.mar);
        end
    end

endmodule

/* verilog/mem_subsystem.sv */
`timescale 1ns/1ps

module mem_subsystem
    import rv32i_types::*;
(
    input  logic          clk,
    input  logic          reset,
    input  ex_mem_stage_t mem_in,
    output wb_result_t    wb_out
);

    // MEM to WB record
    mem_wb_stage_t                  mem_out;

    // shared memory strobes and data
    logic [DMEM_ADDR_WIDTH-1:0]     dmem_index;
    logic [8*DMEM_LANES-1:0]        dmem_wdata;
    logic [8*DMEM_LANES-1:0]        dmem_rdata;
    logic [DMEM_LANES-1:0]          mem_byte_enable;
    logic                           dmem_read;

    mem_stage u_mem_stage (
        .mem_in          (mem_in),
        .mem_out         (mem_out),
        .dmem_index      (dmem_index),
        .dmem_wdata      (dmem_wdata),
        .mem_byte_enable (mem_byte_enable),
        .dmem_read       (dmem_read)
    );

    // one bank per byte lane sharing index and read
    for (genvar i = 0; i < DMEM_LANES; i++) begin : g_lane
        byte_bank u_bank (
            .clk   (clk),
            .reset (reset),
            .index (dmem_index),
            .wdata (dmem_wdata[8*i +: 8]),
            .write (mem_byte_enable[i]),
            .read  (dmem_read),
            .rdata (dmem_rdata[8*i +: 8])
        );
    end

    writeback u_writeback (
        .clk        (clk),
        .reset      (reset),
        .mem_out    (mem_out),
        .dmem_rdata (dmem_rdata),
        .wb_out     (wb_out)
    );

endmodule

/* verilog/rv32i_types.sv */
package rv32i_types;

    // data memory geometry
    // word index width for 256 words of 4 bytes
    localparam int DMEM_ADDR_WIDTH = 8;
    // one bank per byte of a word
    localparam int DMEM_LANES = 4;

    // base opcodes from instr[6:0]
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode_t;

    // load widths in the funct3 field
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_t;

    // store widths in the funct3 field
    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_t;

    // memory side of the control word
    typedef struct packed {
        logic          mem_read;
        logic          mem_write;
        load_funct3_t  load_funct3;
        store_funct3_t store_funct3;
    } mem_ctrl_t;

    // decoded control carried down the pipe
    typedef struct packed {
        rv32i_opcode_t opcode;
        mem_ctrl_t     mem_ctrlwd;
    } ctrl_word_t;

    // EX/MEM register contents
    typedef struct packed {
        logic        valid;
        ctrl_word_t  ctrl_wd;
        logic [4:0]  rd;
        logic [31:0] alu_out;
        // byte address of the access
        logic [31:0] mar;
        // store source still in the low lanes
        logic [31:0] mem_data_out;
        logic [31:0] u_imm;
    } ex_mem_stage_t;

    // MEM/WB register contents
    typedef struct packed {
        logic        valid;
        ctrl_word_t  ctrl_wd;
        logic [4:0]  rd;
        logic [31:0] alu_out;
        logic [31:0] u_imm;
        // byte offset inside the loaded word
        logic [1:0]  mar_low;
    } mem_wb_stage_t;

    // register file write request
    typedef struct packed {
        logic        reg_write;
        logic [4:0]  rd;
        logic [31:0] value;
    } wb_result_t;

endpackage

/* verilog/writeback.sv */
`timescale 1ns/1ps

module writeback
    import rv32i_types::*;
(
    input  logic          clk,
    input  logic          reset,
    input  mem_wb_stage_t mem_out,
    input  logic [31:0]   dmem_rdata,
    output wb_result_t    wb_out
);

    mem_wb_stage_t wb_reg;
    logic [7:0]    load_byte;
    logic [15:0]   load_half;
    logic [31:0]   load_data;
    rv32i_opcode_t opcode;

    // MEM/WB register with only valid cleared on reset
    always_ff @(posedge clk) begin
        wb_reg <= mem_out;
        if (reset) begin
            wb_reg.valid <= 1'b0;
        end
    end

    assign opcode = wb_reg.ctrl_wd.opcode;

    // lane pick from the byte offset
    assign load_byte = dmem_rdata[8*wb_reg.mar_low +: 8];
    assign load_half = wb_reg.mar_low[1] ? dmem_rdata[31:16] : dmem_rdata[15:0];

    // sign or zero extend by width
    always_comb begin
        case (wb_reg.ctrl_wd.mem_ctrlwd.load_funct3)
            lb:  load_data = {{24{load_byte[7]}}, load_byte};
            lbu: load_data = {24'b0, load_byte};
            lh:  load_data = {{16{load_half[15]}}, load_half};
            lhu: load_data = {16'b0, load_half};
            lw:  load_data = dmem_rdata;
            default: load_data = dmem_rdata;
        endcase
    end

    // result select
    always_comb begin
        case (opcode)
            op_load: wb_out.value = load_data;
            op_lui:  wb_out.value = wb_reg.u_imm;
            // alu already formed pc+4 or pc+imm for jumps and auipc
            default: wb_out.value = wb_reg.alu_out;
        endcase
    end

    // stores and branches have no destination and x0 is never written
    assign wb_out.reg_write = wb_reg.valid && (opcode != op_store) && (opcode != op_br)
                              && (wb_reg.rd != 5'd0);
    assign wb_out.rd = wb_reg.rd;

    // a load of a word never stored would leave X in the bank register
    a_load_known: assert property (
        @(posedge clk) disable iff (reset)
        (wb_out.reg_write && opcode == op_load) |-> !$isunknown(wb_out.value)
    ) else $error("writeback: load of unwritten memory");

endmodule
